// File: all.f
board_pkg.sv
game_reset.sv
input_mapper.sv
status_decode.sv
arcade_board.sv
tb_clock.sv
tb_arcade_board.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_arcade_board
FILELIST := all.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell cat $(FILELIST))

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb_arcade_board.sv
// Testbench for the arcade board control core
// Applies a table of input words and compares the outputs with a
// reference model; game reset timing is followed cycle by cycle
`timescale 1ns/1ps

module tb_arcade_board import board_pkg::*; ();
    localparam int VERTICAL  = 1;
    localparam int GRST_LEN  = 16;
    localparam int HOLD      = 3; // Cycles each entry is applied
    localparam int PAUSE_BIT = 9;

    localparam key_in_t                NO_KEYS   = '0;
    localparam logic [BOARD_JOY_W-1:0] JOY_PAUSE = 16'h0200;
    localparam logic [31:0]            FLIP_ST   = 32'h0000_1000;

    typedef struct {
        int                     test;
        logic                   rst_req;
        logic [BOARD_JOY_W-1:0] joy1;
        logic [BOARD_JOY_W-1:0] joy2;
        key_in_t                keys;
        logic [31:0]            status;
    } entry_t;

    logic                   clk_sys;
    logic                   rst;
    logic                   rst_req;
    logic                   downloading;
    logic [BOARD_JOY_W-1:0] board_joy1;
    logic [BOARD_JOY_W-1:0] board_joy2;
    key_in_t                keys;
    logic [31:0]            status;
    game_in_t               game_in;
    logic [GFX_W-1:0]       gfx_en;
    board_cfg_t             cfg;
    logic                   game_rst;
    logic                   game_rst_n;

    entry_t      table_q[$];
    int          table_len = 0;
    logic [31:0] seed      = 32'hb0b3;
    int          errors    = 0;
    int          cur_test  = 0;
    int          test_errors[7];
    string       test_name[7] = '{"", "reset state", "input mapping", "pause",
                                  "graphics enables", "game reset triggers", "settings decode"};

    // Reference game reset
    logic       exp_grst       = 1'b1;
    int         hold_left      = GRST_LEN;
    logic [1:0] rst_n_pipe     = 2'b00;
    logic       late_trig      = 1'b0; // Soft reset or flip change, one cycle late
    logic       last_key_reset = 1'b0;
    logic       last_flip      = 1'b0;

    tb_clock #(.PERIOD(8), .RST_CYCLES(8)) i_tb_clock (.clk_sys(clk_sys), .rst(rst));

    arcade_board #(
        .VERTICAL        (VERTICAL),
        .GAME_RST_CYCLES (GRST_LEN)
    ) i_arcade_board (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .board_joy1  (board_joy1),
        .board_joy2  (board_joy2),
        .keys        (keys),
        .status      (status),
        .game_in     (game_in),
        .gfx_en      (gfx_en),
        .cfg         (cfg),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

    always @(posedge clk_sys) begin
        late_trig      <= (keys.reset & ~last_key_reset) | (status[ST_FLIP] != last_flip);
        last_key_reset <= keys.reset;
        last_flip      <= status[ST_FLIP];
        if (rst || rst_req || downloading || late_trig) begin
            exp_grst  <= 1'b1;
            hold_left <= GRST_LEN;
        end else if (hold_left != 0) begin
            exp_grst  <= (hold_left > 1);
            hold_left <= hold_left - 1;
        end
        if (rst || exp_grst) begin
            rst_n_pipe <= 2'b00;
        end else begin
            rst_n_pipe <= {rst_n_pipe[0], 1'b1}; // Released two cycles late
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Quarter turn of the direction bits
    function automatic logic [JOY_W-1:0] turn_dirs(input logic [JOY_W-1:0] j, input logic rot);
        logic [JOY_W-1:0] t;
        t = j;
        if (rot) begin
            t[3] = j[0];
            t[2] = j[1];
            t[1] = j[3];
            t[0] = j[2];
        end
        return t;
    endfunction

    function automatic game_in_t expect_game_in(input entry_t e);
        game_in_t g;
        logic     rot;
        rot         = (VERTICAL != 0) && !e.status[ST_ROTATE];
        g.joystick1 = turn_dirs(e.joy1[JOY_W-1:0] | e.keys.joy1, rot);
        g.joystick2 = turn_dirs(e.joy2[JOY_W-1:0] | e.keys.joy2, rot);
        g.coin      = {e.joy2[8] | e.keys.coin[1], e.joy1[8] | e.keys.coin[0]};
        g.start     = {e.joy1[7] | e.joy2[7] | e.keys.start[1],
                       e.joy1[6] | e.joy2[6] | e.keys.start[0]};
        g.service   = e.keys.service;
        return game_in_t'(~g); // Active low
    endfunction

    function automatic board_cfg_t expect_cfg(input logic [31:0] st, input logic paused);
        board_cfg_t c;
        logic [7:0] w;
        logic [7:0] h;
        w             = st[ST_ASPECT] ? 8'd16 : 8'd4;
        h             = st[ST_ASPECT] ? 8'd9 : 8'd3;
        c.rot_control = (VERTICAL != 0) && !st[ST_ROTATE];
        c.aspect_x    = c.rot_control ? h : w;
        c.aspect_y    = c.rot_control ? w : h;
        c.rotate      = {st[ST_FLIP], st[ST_ROTATE]};
        c.enable_fm   = !st[ST_FM_OFF];
        c.enable_psg  = !st[ST_PSG_OFF];
        c.dip_test    = st[ST_TEST];
        c.dip_pause   = !paused;
        c.dip_flip    = st[ST_FLIP];
        c.fx_level    = st[14:13];
        return c;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors[cur_test]++;
        end
    endtask

    task automatic step_and_check_reset();
        @(negedge clk_sys);
        check_value({31'h0, game_rst}, {31'h0, exp_grst}, "game_rst");
        check_value({31'h0, game_rst_n}, {31'h0, rst_n_pipe[1]}, "game_rst_n");
    endtask

    task automatic fill_table();
        key_in_t     k;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        for (int i = 0; i < 8; i++) begin
            table_q.push_back('{1, 1'b0, 16'h0, 16'h0, NO_KEYS, 32'h0});
        end
        for (int i = 0; i < 24; i++) begin
            r1 = next_rand();
            r2 = next_rand();
            r3 = next_rand();
            k = key_in_t'({r1[31:16], r2[31:17]});
            k.reset = 1'b0;
            // Rotation alternates, aspect is random
            table_q.push_back('{2, 1'b0, r3[31:16], {r1[15:8], r2[15:8]}, k,
                                {29'h0, i[0], r3[9], 1'b0}});
        end
        k = NO_KEYS;
        k.pause = 1'b1;
        table_q.push_back('{3, 1'b0, 16'h0, 16'h0, k, 32'h0});
        table_q.push_back('{3, 1'b0, 16'h0, 16'h0, k, 32'h0}); // Held high
        table_q.push_back('{3, 1'b0, 16'h0, 16'h0, NO_KEYS, 32'h0});
        table_q.push_back('{3, 1'b0, JOY_PAUSE, 16'h0, NO_KEYS, 32'h0});
        table_q.push_back('{3, 1'b0, JOY_PAUSE, 16'h0, NO_KEYS, 32'h0});
        table_q.push_back('{3, 1'b0, 16'h0, 16'h0, NO_KEYS, 32'h0});
        table_q.push_back('{3, 1'b0, 16'h0, JOY_PAUSE, NO_KEYS, 32'h0});
        table_q.push_back('{3, 1'b0, 16'h0, 16'h0, NO_KEYS, 32'h0});
        for (int i = 0; i < GFX_W; i++) begin
            k = NO_KEYS;
            k.gfx[i] = 1'b1;
            table_q.push_back('{4, 1'b0, 16'h0, 16'h0, k, 32'h0});
            table_q.push_back('{4, 1'b0, 16'h0, 16'h0, NO_KEYS, 32'h0});
        end
        // rst_req, then the reset key, then a flip change
        k = NO_KEYS;
        k.reset = 1'b1;
        for (int n = 0; n < 24; n++) begin
            r1 = (n >= 16) ? FLIP_ST : 32'h0;
            table_q.push_back('{5, n == 0, 16'h0, 16'h0, (n == 8) ? k : NO_KEYS, r1});
        end
        for (int i = 0; i < 12; i++) begin
            table_q.push_back('{6, 1'b0, 16'h0, 16'h0, NO_KEYS, next_rand()});
        end
        table_len = table_q.size();
    endtask

    initial begin
        entry_t           e;
        entry_t           prev;
        logic             exp_pause;
        logic [GFX_W-1:0] exp_gfx;
        int               next_test;
        int               failed;
        rst_req     = 1'b0;
        downloading = 1'b0;
        board_joy1  = '0;
        board_joy2  = '0;
        keys        = '0;
        status      = '0;
        exp_pause   = 1'b0;
        exp_gfx     = '1;
        failed      = 0;
        fill_table();
        prev = table_q[0]; // All zero, as the edge detectors after reset
        @(negedge rst);
        // Values held by reset, before any entry is applied
        cur_test = 1;
        check_value({7'h0, game_in}, 32'h01ff_ffff, "game_in after reset");
        check_value({28'h0, gfx_en}, 32'h0000_000f, "gfx_en after reset");
        check_value({31'h0, cfg.dip_pause}, 32'h1, "dip_pause after reset");
        check_value({30'h0, game_rst, game_rst_n}, 32'h2, "game reset pair after reset");
        foreach (table_q[i]) begin
            e          = table_q[i];
            cur_test   = e.test;
            rst_req    = e.rst_req;
            board_joy1 = e.joy1;
            board_joy2 = e.joy2;
            keys       = e.keys;
            status     = e.status;
            exp_gfx    = exp_gfx ^ (e.keys.gfx & ~prev.keys.gfx);
            if (e.keys.pause && !prev.keys.pause) begin
                exp_pause = !exp_pause;
            end
            // Board pause is seen a cycle after the key, so both can toggle
            if ((e.joy1[PAUSE_BIT] | e.joy2[PAUSE_BIT]) &&
                !(prev.joy1[PAUSE_BIT] | prev.joy2[PAUSE_BIT])) begin
                exp_pause = !exp_pause;
            end
            repeat (HOLD) begin
                step_and_check_reset();
            end
            check_value({7'h0, game_in}, {7'h0, expect_game_in(e)}, "game_in");
            check_value({28'h0, gfx_en}, {28'h0, exp_gfx}, "gfx_en");
            check_value({6'h0, cfg}, {6'h0, expect_cfg(e.status, exp_pause)}, "cfg");
            prev      = e;
            next_test = (i + 1 < table_len) ? table_q[i + 1].test : 0;
            if (next_test != e.test) begin
                $display("test %0d %s: %0d errors", e.test, test_name[e.test],
                         test_errors[e.test]);
            end
        end
        for (int t = 1; t <= 6; t++) begin
            if (test_errors[t] != 0) begin
                failed++;
            end
        end
        $display("6 tests run, %0d failed, %0d checks failed", failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_len != 0);
        repeat (table_len * 40 + 200) begin
            @(posedge clk_sys);
        end
        $display("Timeout: the table did not finish in %0d cycles", table_len * 40 + 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: tb_clock.sv
// Testbench clock and power-on reset
// Free running clk_sys, with rst held high for the first RST_CYCLES edges
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD     = 8, // ns
    parameter int RST_CYCLES = 8
) (
    output logic clk_sys,
    output logic rst
);
    initial begin
        clk_sys = 1'b0;
        forever begin
            #(PERIOD / 2) clk_sys = ~clk_sys;
        end
    end

    // Released on a falling edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) begin
            @(posedge clk_sys);
        end
        @(negedge clk_sys);
        rst = 1'b0;
    end

endmodule

// File: arcade_board.sv
// Arcade board control core
// Ties together input conditioning, settings decoding and the
// game reset sequencer
`timescale 1ns/1ps

module arcade_board import board_pkg::*; #(
    parameter int THREE_BUTTONS   = 0,
    parameter int ACTIVE_LOW      = 1,
    parameter int VERTICAL        = 0,
    parameter int GAME_RST_CYCLES = 256
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   rst_req,
    input  logic                   downloading,
    input  logic [BOARD_JOY_W-1:0] board_joy1,
    input  logic [BOARD_JOY_W-1:0] board_joy2,
    input  key_in_t                keys,
    input  logic [31:0]            status,
    output game_in_t               game_in,
    output logic [GFX_W-1:0]       gfx_en,
    output board_cfg_t             cfg,
    output logic                   game_rst,
    output logic                   game_rst_n
);
    logic game_pause; // Level from the pause toggle
    logic soft_rst;   // One cycle pulse from the reset key

    input_mapper #(
        .THREE_BUTTONS (THREE_BUTTONS),
        .ACTIVE_LOW    (ACTIVE_LOW)
    ) i_input_mapper (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .board_joy1  (board_joy1),
        .board_joy2  (board_joy2),
        .keys        (keys),
        .rot_control (cfg.rot_control),
        .game_in     (game_in),
        .game_pause  (game_pause),
        .soft_rst    (soft_rst),
        .gfx_en      (gfx_en)
    );

    status_decode #(
        .VERTICAL (VERTICAL)
    ) i_status_decode (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .status     (status),
        .game_pause (game_pause),
        .cfg        (cfg)
    );

    game_reset #(
        .GAME_RST_CYCLES (GAME_RST_CYCLES)
    ) i_game_reset (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .soft_rst    (soft_rst),
        .dip_flip    (cfg.dip_flip),
        .game_rst    (game_rst),
        .game_rst_n  (game_rst_n)
    );

endmodule

// File: status_decode.sv
// Settings word decoder
// Registers DIP style controls, rotation and the aspect ratio
`timescale 1ns/1ps

module status_decode import board_pkg::*; #(
    parameter int VERTICAL = 0
) (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic [31:0] status,
    input  logic        game_pause,
    output board_cfg_t  cfg
);
    localparam logic IS_VERT = (VERTICAL != 0);

    board_cfg_t cfg_nxt;
    logic [7:0] asp_w;
    logic [7:0] asp_h;

    // Screen proportions before rotation
    assign asp_w = status[ST_ASPECT] ? 8'd16 : 8'd4;
    assign asp_h = status[ST_ASPECT] ? 8'd9  : 8'd3;

    always_comb begin
        cfg_nxt.rot_control = IS_VERT & ~status[ST_ROTATE];
        cfg_nxt.dip_flip    = status[ST_FLIP];
        cfg_nxt.rotate      = {status[ST_FLIP], status[ST_ROTATE]};
        cfg_nxt.dip_test    = status[ST_TEST];
        cfg_nxt.fx_level    = status[ST_FX_LO+1:ST_FX_LO];
        cfg_nxt.enable_fm   = ~status[ST_FM_OFF];
        cfg_nxt.enable_psg  = ~status[ST_PSG_OFF];
        cfg_nxt.dip_pause   = ~game_pause; // Game sees pause active low

        // Turned screen swaps the proportions
        if (cfg_nxt.rot_control) begin
            cfg_nxt.aspect_x = asp_h;
            cfg_nxt.aspect_y = asp_w;
        end else begin
            cfg_nxt.aspect_x = asp_w;
            cfg_nxt.aspect_y = asp_h;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cfg           <= '0;
            cfg.dip_pause <= 1'b1; // Not paused
        end else begin
            cfg <= cfg_nxt;
        end
    end

endmodule

// File: input_mapper.sv
// Player input conditioning
// Board joysticks are synchronised and merged with decoded keys, then
// rotated and set to the game polarity. Also keeps the pause level,
// the soft reset pulse and the graphics layer toggles
`timescale 1ns/1ps

module input_mapper import board_pkg::*; #(
    parameter int THREE_BUTTONS = 0,
    parameter int ACTIVE_LOW    = 1
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic [BOARD_JOY_W-1:0] board_joy1,
    input  logic [BOARD_JOY_W-1:0] board_joy2,
    input  key_in_t                keys,
    input  logic                   rot_control,
    output game_in_t               game_in,
    output logic                   game_pause,
    output logic                   soft_rst,
    output logic [GFX_W-1:0]       gfx_en
);
    // Button positions on the board joystick word
    localparam int START1_BIT = 6 + THREE_BUTTONS;
    localparam int START2_BIT = 7 + THREE_BUTTONS;
    localparam int COIN_BIT   = 8 + THREE_BUTTONS;
    localparam int PAUSE_BIT  = 9 + THREE_BUTTONS;

    localparam int       GI_W     = $bits(game_in_t);
    localparam logic     INV      = (ACTIVE_LOW != 0);
    localparam game_in_t INACTIVE = game_in_t'({GI_W{INV}});

    logic [BOARD_JOY_W-1:0] joy1_sync;
    logic [BOARD_JOY_W-1:0] joy2_sync;
    game_in_t               game_nxt;
    logic                   joy_pause;
    logic                   last_pause;
    logic                   last_joypause;
    logic                   last_reset;
    logic [GFX_W-1:0]       last_gfx;
    logic                   pause_edge;

    // Turns the directions a quarter for rotated screens
    function automatic logic [JOY_W-1:0] rotate_joy(
        input logic [JOY_W-1:0] joy,
        input logic             rot
    );
        logic [JOY_W-1:0] turned;
        turned = {joy[JOY_W-1:4], joy[0], joy[1], joy[3], joy[2]};
        return rot ? turned : joy;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joy1;
        joy2_sync <= board_joy2;
    end

    assign joy_pause  = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];
    assign pause_edge = (keys.pause & ~last_pause) | (joy_pause & ~last_joypause);

    // Active high view of the game inputs
    always_comb begin
        game_nxt.joystick1 = rotate_joy(joy1_sync[JOY_W-1:0] | keys.joy1, rot_control);
        game_nxt.joystick2 = rotate_joy(joy2_sync[JOY_W-1:0] | keys.joy2, rot_control);
        game_nxt.coin      = {joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]} | keys.coin;
        game_nxt.start     = {joy1_sync[START2_BIT], joy1_sync[START1_BIT]}
                           | {joy2_sync[START2_BIT], joy2_sync[START1_BIT]}
                           | keys.start;
        game_nxt.service   = keys.service;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_in       <= INACTIVE;
            game_pause    <= 1'b0;
            soft_rst      <= 1'b0;
            gfx_en        <= '1; // All layers shown
            last_pause    <= 1'b0;
            last_joypause <= 1'b0;
            last_reset    <= 1'b0;
            last_gfx      <= '0;
        end else begin
            last_pause    <= keys.pause;
            last_joypause <= joy_pause;
            last_reset    <= keys.reset;
            last_gfx      <= keys.gfx;

            game_in    <= game_in_t'(game_nxt ^ INACTIVE); // Game polarity
            soft_rst   <= keys.reset & ~last_reset;
            game_pause <= game_pause ^ pause_edge;
            gfx_en     <= gfx_en ^ (keys.gfx & ~last_gfx); // Toggle per layer
        end
    end

endmodule

// File: game_reset.sv
// Game reset sequencer
// Any trigger holds game_rst high, which is then stretched for
// GAME_RST_CYCLES cycles; game_rst_n follows two cycles after release
`timescale 1ns/1ps

module game_reset import board_pkg::*; #(
    parameter int GAME_RST_CYCLES = 256
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic game_rst,
    output logic game_rst_n
);
    localparam int CNT_W = $clog2(GAME_RST_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(GAME_RST_CYCLES - 1);

    grst_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic             last_dip_flip;
    logic             trigger;
    logic             pre_rst_n;

    // A flip change restarts the game with the new screen orientation
    always_ff @(posedge clk_sys) begin
        last_dip_flip <= dip_flip;
    end

    assign trigger = rst | rst_req | downloading | soft_rst | (dip_flip != last_dip_flip);

    always_ff @(posedge clk_sys) begin
        if (trigger) begin // rst is one of the triggers
            state    <= GRST_HOLD;
            cnt      <= '0;
            game_rst <= 1'b1;
        end else begin
            case (state)
                GRST_HOLD, GRST_COUNT: begin
                    if (cnt == CNT_LAST) begin
                        state    <= GRST_RUN;
                        game_rst <= 1'b0;
                    end else begin
                        state <= GRST_COUNT;
                        cnt   <= cnt + 1'b1;
                    end
                end
                default: game_rst <= 1'b0; // GRST_RUN
            endcase
        end
    end

    // Two stage release of the active low copy
    always_ff @(posedge clk_sys) begin
        if (rst || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

endmodule

// File: board_pkg.sv
// Shared definitions for the arcade board control core
// Widths, settings word bit positions, the bundled port types
// and the game reset sequencer states
package board_pkg;

    localparam int JOY_W       = 10; // Game joystick word
    localparam int BOARD_JOY_W = 16; // Raw board joystick
    localparam int GFX_W       = 4;  // Graphics layer enables

    // Settings word bits
    localparam int ST_ASPECT  = 1;  // 1 selects 16:9
    localparam int ST_ROTATE  = 2;  // 1 keeps a vertical game unrotated
    localparam int ST_FM_OFF  = 8;
    localparam int ST_PSG_OFF = 9;
    localparam int ST_TEST    = 10;
    localparam int ST_FLIP    = 12;
    localparam int ST_FX_LO   = 13; // Effects level in 14:13

    // Keys already decoded from the keyboard
    typedef struct packed {
        logic [JOY_W-1:0] joy1;
        logic [JOY_W-1:0] joy2;
        logic [1:0]       start;
        logic [1:0]       coin;
        logic             reset;
        logic             pause;
        logic             service;
        logic [GFX_W-1:0] gfx;
    } key_in_t;

    // What the game core sees
    typedef struct packed {
        logic [JOY_W-1:0] joystick1;
        logic [JOY_W-1:0] joystick2;
        logic [1:0]       coin;
        logic [1:0]       start;
        logic             service;
    } game_in_t;

    typedef struct packed {
        logic [7:0] aspect_x;
        logic [7:0] aspect_y;
        logic [1:0] rotate;      // {flip, no rotation}
        logic       rot_control; // Joystick directions turned
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_test;
        logic       dip_pause;   // Low while paused
        logic       dip_flip;
        logic [1:0] fx_level;
    } board_cfg_t;

    typedef enum logic [1:0] {
        GRST_HOLD,  // A trigger is present
        GRST_COUNT, // Stretching after the last trigger
        GRST_RUN    // Game released
    } grst_state_e;

endpackage
